//--- core_wrap.f
+incdir+hdl
hdl/core_pkg.sv
hdl/cdc_sync.sv
hdl/core_decode.sv
hdl/core_execute.sv
hdl/core_result.sv
hdl/core_hart.sv
hdl/core_wrap.sv
sim/core_checker.sv
sim/tb_core_wrap.sv

//--- sim/tb_core_wrap.sv
// testbench for the wrapped hart, random instruction stream from a memory responder
// run core_wrap.f with tb_core_wrap as top, core_checker does the comparing
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_core_wrap
  import core_pkg::*;
();

  localparam int RUN1        = 200;
  localparam int ZERO_STORES = `CORE_NREG;
  localparam int RUN2        = 150;
  localparam int WAKE_CYCLES = (1 << (`CORE_WAKE_BITS - 1)) + 2;
  // worst case instruction is well under 12 cycles
  localparam int TIMEOUT_CYCLES = (RUN1 + ZERO_STORES + RUN2) * 12 + 2 * (WAKE_CYCLES + 5) + 200;

  logic                         clk = 1'b0;
  logic                         reset_l;
  logic [`CORE_ALEN-1:0]        boot_addr;
  logic [`CORE_XLEN-1:0]        hart_id;
  logic [1:0]                   irq;
  logic                         debug_req;
  logic                         core_rst_l;
  logic [$bits(mem_req_t)-1:0]  mem_req;
  logic [$bits(mem_resp_t)-1:0] mem_resp;
  int                           err_cnt;
  int                           check_cnt;
  int                           retired;
  logic [31:0]                  rng_state;
  logic [31:0]                  forced_q [$];

  always #2 clk = ~clk;

  core_wrap dut0 (
    .clk_i        ( clk        ),
    .reset_l      ( reset_l    ),
    .boot_addr_i  ( boot_addr  ),
    .hart_id_i    ( hart_id    ),
    .irq_i        ( irq        ),
    .debug_req_i  ( debug_req  ),
    .core_rst_l_o ( core_rst_l ),
    .mem_req_o    ( mem_req    ),
    .mem_resp_i   ( mem_resp   )
  );

  core_checker chk0 (
    .clk_i        ( clk        ),
    .reset_l      ( reset_l    ),
    .core_rst_l_i ( core_rst_l ),
    .boot_addr_i  ( boot_addr  ),
    .hart_id_i    ( hart_id    ),
    .irq_i        ( irq        ),
    .debug_req_i  ( debug_req  ),
    .mem_req_i    ( mem_req    ),
    .mem_resp_i   ( mem_resp   ),
    .err_cnt_o    ( err_cnt    ),
    .check_cnt_o  ( check_cnt  ),
    .retired_o    ( retired    )
  );

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // queued instructions go first, otherwise a random one
  function automatic logic [31:0] pick_instr();
    logic [31:0] sel;
    logic [31:0] instr;
    if (forced_q.size() > 0) begin
      instr = forced_q.pop_front();
    end else begin
      sel   = next_rand();
      instr = next_rand();
      // about one in eight is an opcode the hart does not know
      if (sel[2:0] == 3'd0) begin
        instr[31:28] = 4'(6 + sel[15:8] % 10);
      end else begin
        instr[31:28] = 4'(sel[15:8] % 6);
      end
    end
    return instr;
  endfunction

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory responder
  ////////////////////////////////////////////////////////////

  initial begin : responder
    mem_req_t    req;
    mem_resp_t   resp;
    logic [31:0] instr;
    logic [31:0] lvl;
    int          delay;
    mem_resp  = '0;
    irq       = 2'b00;
    debug_req = 1'b0;
    forever begin
      @(negedge clk);
      req = mem_req;
      if (req.valid && !req.we) begin
        instr = pick_instr();
        delay = 1 + int'(next_rand() % 4);
        repeat (delay) @(posedge clk);
        #1;
        resp.valid = 1'b1;
        resp.rdata = instr;
        mem_resp   = resp;
        // levels move only beside an instruction that does not read them
        if (instr[31:28] != `CORE_OP_IRQ) begin
          lvl = next_rand();
          if (lvl[7:6] == 2'b00) begin
            irq       = lvl[1:0];
            debug_req = lvl[2];
          end
        end
        @(posedge clk);
        #1;
        mem_resp = '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] tmp;
    logic [31:0] instr;
    int          errs;
    rng_state = 32'd92722;
    reset_l   = 1'b0;
    tmp       = next_rand();
    boot_addr = {tmp[15:2], 2'b00};
    hart_id   = next_rand();
    repeat (5) @(posedge clk);
    #1 reset_l = 1'b1;

    errs = err_cnt;
    wait (retired >= 1);
    report_test("wake-up and boot fetch", errs);

    errs = err_cnt;
    wait (retired >= RUN1);
    report_test("random instruction run", errs);

    // pulse reset in the middle of the stream, new boot address
    errs = err_cnt;
    @(posedge clk);
    #1 reset_l = 1'b0;
    tmp       = next_rand();
    boot_addr = {tmp[15:2], 2'b00};
    repeat (3) @(posedge clk);
    #1 reset_l = 1'b1;
    // store every register, all should read zero
    for (int r = 0; r < `CORE_NREG; r++) begin
      instr        = '0;
      instr[31:28] = `CORE_OP_STORE;
      instr[18:16] = r[2:0];
      instr[15:0]  = 16'h0200 + 16'(r * 4);
      forced_q.push_back(instr);
    end
    wait (retired >= RUN1 + ZERO_STORES);
    report_test("reset mid-run and zeroed registers", errs);

    errs = err_cnt;
    wait (retired >= RUN1 + ZERO_STORES + RUN2);
    repeat (6) @(posedge clk);
    report_test("random run after reset", errs);

    $display("summary: %0d instructions, %0d checks, %0d errors", retired, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("ERROR: run timed out after %0d cycles with %0d instructions retired",
             TIMEOUT_CYCLES, retired);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- sim/core_checker.sv
// instruction-set model of the hart, watches the wrapper ports and checks every request
// counts checks, errors and retired instructions for the testbench top
`timescale 1ns/1ps
`include "core_defs.svh"

module core_checker
  import core_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_l,
  input  logic                          core_rst_l_i,
  input  logic [`CORE_ALEN-1:0]         boot_addr_i,
  input  logic [`CORE_XLEN-1:0]         hart_id_i,
  input  logic [1:0]                    irq_i,
  input  logic                          debug_req_i,
  input  logic [$bits(mem_req_t)-1:0]   mem_req_i,
  input  logic [$bits(mem_resp_t)-1:0]  mem_resp_i,
  output int                            err_cnt_o,
  output int                            check_cnt_o,
  output int                            retired_o
);

  // core reset release, counted in clock edges after reset_l goes high
  localparam int WAKE_CYCLES = (1 << (`CORE_WAKE_BITS - 1)) + 2;

  typedef enum logic [1:0] {EXP_NONE, EXP_READ, EXP_STORE} exp_kind_t;

  mem_req_t              req;
  mem_resp_t             resp;
  int                    cyc;
  int                    edges_since_rel;
  bit                    wake_wait;
  bit                    outstanding;
  exp_kind_t             exp_kind;
  int                    exp_cyc;
  logic [`CORE_ALEN-1:0] exp_addr;
  logic [`CORE_XLEN-1:0] exp_wdata;
  logic [`CORE_ALEN-1:0] pc;
  logic [`CORE_XLEN-1:0] regs [`CORE_NREG];

  initial begin
    err_cnt_o   = 0;
    check_cnt_o = 0;
    retired_o   = 0;
    cyc         = 0;
    wake_wait   = 1'b1;
    outstanding = 1'b0;
    exp_kind    = EXP_NONE;
  end

  task automatic compare(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
    check_cnt_o++;
    if (exp_val !== act_val) begin
      err_cnt_o++;
      $display("FAILED t=%0t %s expected 'h%0h got 'h%0h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic report_problem(input string msg);
    err_cnt_o++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  task automatic check_request();
    if (exp_kind == EXP_NONE) begin
      if (outstanding && !req.we) begin
        report_problem("read issued while another read is outstanding");
      end else begin
        report_problem("memory request issued when none was expected");
      end
    end else begin
      compare("mem_req_o cycle", exp_cyc, cyc);
      compare("mem_req_o.we", exp_kind == EXP_STORE, req.we);
      compare("mem_req_o.addr", exp_addr, req.addr);
      if (exp_kind == EXP_STORE) begin
        compare("mem_req_o.wdata", exp_wdata, req.wdata);
        // fetch follows the store by one cycle
        exp_kind = EXP_READ;
        exp_cyc  = cyc + 1;
        exp_addr = pc;
      end else begin
        outstanding = 1'b1;
        exp_kind    = EXP_NONE;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // instruction model
  ////////////////////////////////////////////////////////////

  task automatic run_instr(input logic [31:0] instr);
    logic [3:0]            op;
    logic [2:0]            rd;
    logic [2:0]            rs1;
    logic [2:0]            rs2;
    logic [`CORE_XLEN-1:0] imm;
    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    if (!outstanding) begin
      report_problem("read response arrived with no read outstanding");
    end
    outstanding = 1'b0;
    retired_o++;
    op  = instr[31:28];
    rd  = instr[26:24];
    rs1 = instr[22:20];
    rs2 = instr[18:16];
    imm = {{16{instr[15]}}, instr[15:0]};
    a   = regs[rs1];
    b   = regs[rs2];
    pc  = pc + 16'd4;
    // response seen half a cycle before decode registers it, so three negedges to the request
    exp_kind = EXP_READ;
    exp_cyc  = cyc + 3;
    exp_addr = pc;
    case (op)
      `CORE_OP_ADDI: regs[rd] = a + imm;
      `CORE_OP_ADD:  regs[rd] = a + b;
      `CORE_OP_XOR:  regs[rd] = a ^ b;
      `CORE_OP_STORE: begin
        exp_kind  = EXP_STORE;
        exp_addr  = imm[`CORE_ALEN-1:0];
        exp_wdata = b;
      end
      `CORE_OP_HART: regs[rd] = hart_id_i;
      `CORE_OP_IRQ:  regs[rd] = {29'd0, debug_req_i, irq_i};
      // anything else leaves the registers alone
      default: ;
    endcase
  endtask

  // reset_l only moves after a rising edge, so it is stable here
  always @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      edges_since_rel <= 0;
    end else begin
      edges_since_rel <= edges_since_rel + 1;
    end
  end

  // outputs are sampled mid-cycle
  always @(negedge clk_i) begin
    cyc  = cyc + 1;
    req  = mem_req_i;
    resp = mem_resp_i;
    if (!core_rst_l_i) begin
      outstanding = 1'b0;
      exp_kind    = EXP_NONE;
      for (int i = 0; i < `CORE_NREG; i++) begin
        regs[i] = '0;
      end
      if (!reset_l) begin
        wake_wait = 1'b1;
      end else if (wake_wait && edges_since_rel > WAKE_CYCLES) begin
        report_problem("core reset still low after the wake-up time");
        wake_wait = 1'b0;
      end
      if (req.valid) begin
        report_problem("memory request while the core is in reset");
      end
    end else begin
      if (wake_wait) begin
        compare("core_rst_l_o rise edge", WAKE_CYCLES, edges_since_rel);
        wake_wait = 1'b0;
        // boot fetch one cycle after the core leaves reset
        pc       = boot_addr_i;
        exp_kind = EXP_READ;
        exp_cyc  = cyc + 1;
        exp_addr = boot_addr_i;
      end
      if (req.valid) begin
        check_request();
      end
      if (resp.valid) begin
        run_instr(resp.rdata);
      end
      if (exp_kind != EXP_NONE && cyc >= exp_cyc) begin
        report_problem("expected memory request did not appear");
        exp_kind = EXP_NONE;
      end
    end
  end

endmodule

//--- hdl/core_wrap.sv
// top level around the hart, flat vectors outside and structs inside
// holds the hart in reset for a wake-up count, then syncs reset, irq and debug
`timescale 1ns/1ps
`include "core_defs.svh"

module core_wrap
  import core_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_l,
  // static after reset
  input  logic [`CORE_ALEN-1:0]         boot_addr_i,
  input  logic [`CORE_XLEN-1:0]         hart_id_i,
  // asynchronous levels
  input  logic [1:0]                    irq_i,
  input  logic                          debug_req_i,
  output logic                          core_rst_l_o,
  // memory side
  output logic [$bits(mem_req_t)-1:0]   mem_req_o,
  input  logic [$bits(mem_resp_t)-1:0]  mem_resp_i
);

  mem_req_t  mem_req;
  mem_resp_t mem_resp;

  // struct to vector and back
  assign mem_req_o = mem_req;
  assign mem_resp  = mem_resp_i;

  ////////////////////////////////////////////////////////////
  // wake-up counter
  ////////////////////////////////////////////////////////////

  // lets the outside memories finish initialising
  logic [`CORE_WAKE_BITS-1:0] wake_cnt_q;
  logic [`CORE_WAKE_BITS-1:0] wake_cnt_d;
  logic                       rst_gate_l;

  // count until the top bit sets, then hold
  assign wake_cnt_d = wake_cnt_q[`CORE_WAKE_BITS-1] ? wake_cnt_q : wake_cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt_q <= '0;
    end else begin
      wake_cnt_q <= wake_cnt_d;
    end
  end

  assign rst_gate_l = wake_cnt_q[`CORE_WAKE_BITS-1] & reset_l;

  ////////////////////////////////////////////////////////////
  // synchronizers
  ////////////////////////////////////////////////////////////

  logic [1:0] irq;
  logic       debug_req;

  // assert is async through reset_l, release comes two edges later
  cdc_sync #(.T(logic)) u_rst_sync (
    .clk_i   ( clk_i        ),
    .reset_l ( reset_l      ),
    .data_i  ( rst_gate_l   ),
    .data_o  ( core_rst_l_o )
  );

  cdc_sync #(.T(logic [1:0])) u_irq_sync (
    .clk_i   ( clk_i   ),
    .reset_l ( reset_l ),
    .data_i  ( irq_i   ),
    .data_o  ( irq     )
  );

  cdc_sync #(.T(logic)) u_debug_sync (
    .clk_i   ( clk_i       ),
    .reset_l ( reset_l     ),
    .data_i  ( debug_req_i ),
    .data_o  ( debug_req   )
  );

  core_hart u_hart (
    .clk_i       ( clk_i        ),
    .reset_l     ( core_rst_l_o ),
    .boot_addr_i ( boot_addr_i  ),
    .hart_id_i   ( hart_id_i    ),
    .irq_i       ( irq          ),
    .debug_req_i ( debug_req    ),
    .mem_req_o   ( mem_req      ),
    .mem_resp_i  ( mem_resp     )
  );

endmodule

//--- hdl/core_hart.sv
// single-issue hart, decode feeds execute feeds result
// result owns the register file and the memory request port
`timescale 1ns/1ps
`include "core_defs.svh"

module core_hart
  import core_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_l,
  input  logic [`CORE_ALEN-1:0] boot_addr_i,
  input  logic [`CORE_XLEN-1:0] hart_id_i,
  input  logic [1:0]            irq_i,
  input  logic                  debug_req_i,
  output mem_req_t              mem_req_o,
  input  mem_resp_t             mem_resp_i
);

  dec_instr_t            dec;
  exe_result_t           res;
  reg_addr_t             rs1_addr;
  reg_addr_t             rs2_addr;
  logic [`CORE_XLEN-1:0] rs1_data;
  logic [`CORE_XLEN-1:0] rs2_data;

  core_decode u_decode (
    .clk_i      ( clk_i      ),
    .reset_l    ( reset_l    ),
    .mem_resp_i ( mem_resp_i ),
    .dec_o      ( dec        )
  );

  core_execute u_execute (
    .clk_i       ( clk_i       ),
    .reset_l     ( reset_l     ),
    .dec_i       ( dec         ),
    .rs1_data_i  ( rs1_data    ),
    .rs2_data_i  ( rs2_data    ),
    .rs1_addr_o  ( rs1_addr    ),
    .rs2_addr_o  ( rs2_addr    ),
    .hart_id_i   ( hart_id_i   ),
    .irq_i       ( irq_i       ),
    .debug_req_i ( debug_req_i ),
    .res_o       ( res         )
  );

  core_result u_result (
    .clk_i       ( clk_i       ),
    .reset_l     ( reset_l     ),
    .boot_addr_i ( boot_addr_i ),
    .res_i       ( res         ),
    .rs1_addr_i  ( rs1_addr    ),
    .rs2_addr_i  ( rs2_addr    ),
    .rs1_data_o  ( rs1_data    ),
    .rs2_data_o  ( rs2_data    ),
    .mem_req_o   ( mem_req_o   )
  );

endmodule

//--- hdl/core_result.sv
// result stage, owns the register file and pc and drives the memory request port
// retires each result, issues its store, then the fetch of the next instruction
`timescale 1ns/1ps
`include "core_defs.svh"

module core_result
  import core_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_l,
  input  logic [`CORE_ALEN-1:0] boot_addr_i,
  input  exe_result_t           res_i,
  input  reg_addr_t             rs1_addr_i,
  input  reg_addr_t             rs2_addr_i,
  output logic [`CORE_XLEN-1:0] rs1_data_o,
  output logic [`CORE_XLEN-1:0] rs2_data_o,
  output mem_req_t              mem_req_o
);

  localparam logic [`CORE_ALEN-1:0] FETCH_STEP = 4;

  logic [`CORE_XLEN-1:0] regs_q [`CORE_NREG];
  logic [`CORE_ALEN-1:0] pc_q;
  logic [`CORE_ALEN-1:0] pc_d;
  // boot fetch still owed, and fetch deferred behind a store
  logic                  boot_q;
  logic                  fetch_pend_q;
  mem_req_t              req_d;
  mem_req_t              req_q;
  logic                  req_valid_q;

  assign rs1_data_o = regs_q[rs1_addr_i];
  assign rs2_data_o = regs_q[rs2_addr_i];

  ////////////////////////////////////////////////////////////
  // request select
  ////////////////////////////////////////////////////////////

  always_comb begin
    req_d = '0;
    pc_d  = pc_q;
    if (boot_q) begin
      req_d.valid = 1'b1;
      req_d.addr  = boot_addr_i;
      pc_d        = boot_addr_i;
    end else if (res_i.valid && res_i.store) begin
      req_d.valid = 1'b1;
      req_d.we    = 1'b1;
      req_d.addr  = res_i.addr;
      req_d.wdata = res_i.value;
    end else if (res_i.valid || fetch_pend_q) begin
      // next sequential fetch
      req_d.valid = 1'b1;
      req_d.addr  = pc_q + FETCH_STEP;
      pc_d        = pc_q + FETCH_STEP;
    end
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      boot_q       <= 1'b1;
      fetch_pend_q <= 1'b0;
      pc_q         <= '0;
      req_valid_q  <= 1'b0;
      for (int i = 0; i < `CORE_NREG; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      boot_q       <= 1'b0;
      fetch_pend_q <= res_i.valid & res_i.store;
      pc_q         <= pc_d;
      req_valid_q  <= req_d.valid;
      // write back
      if (res_i.valid && res_i.wb) begin
        regs_q[res_i.rd] <= res_i.value;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_d.valid) begin
      req_q <= req_d;
    end
  end

  always_comb begin
    mem_req_o       = req_q;
    mem_req_o.valid = req_valid_q;
  end

  // a read is always followed by a quiet cycle, the response takes at least one
  a_read_gap: assert property (@(posedge clk_i) disable iff (!reset_l)
    (mem_req_o.valid && !mem_req_o.we) |=> !mem_req_o.valid);

endmodule

//--- hdl/core_execute.sv
// execute stage, reads operands and computes the result of each instruction
// result is registered and valid one cycle after the decoded instruction
`timescale 1ns/1ps
`include "core_defs.svh"

module core_execute
  import core_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_l,
  input  dec_instr_t            dec_i,
  input  logic [`CORE_XLEN-1:0] rs1_data_i,
  input  logic [`CORE_XLEN-1:0] rs2_data_i,
  output reg_addr_t             rs1_addr_o,
  output reg_addr_t             rs2_addr_o,
  input  logic [`CORE_XLEN-1:0] hart_id_i,
  input  logic [1:0]            irq_i,
  input  logic                  debug_req_i,
  output exe_result_t           res_o
);

  exe_result_t res_d;
  exe_result_t res_q;
  logic        res_valid_q;

  // register file read is combinational
  assign rs1_addr_o = dec_i.rs1;
  assign rs2_addr_o = dec_i.rs2;

  ////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////

  always_comb begin
    res_d       = '0;
    res_d.valid = dec_i.valid;
    res_d.rd    = dec_i.rd;
    res_d.wb    = dec_i.wb;
    res_d.store = (dec_i.op == `CORE_OP_STORE);
    // store target is the low half of the immediate
    res_d.addr  = dec_i.imm[`CORE_ALEN-1:0];
    case (dec_i.op)
      `CORE_OP_ADDI:  res_d.value = rs1_data_i + dec_i.imm;
      `CORE_OP_ADD:   res_d.value = rs1_data_i + rs2_data_i;
      `CORE_OP_XOR:   res_d.value = rs1_data_i ^ rs2_data_i;
      `CORE_OP_STORE: res_d.value = rs2_data_i;
      `CORE_OP_HART:  res_d.value = hart_id_i;
      // debug in bit 2, irq pair below it
      `CORE_OP_IRQ:   res_d.value = {{(`CORE_XLEN-3){1'b0}}, debug_req_i, irq_i};
      default:        res_d.value = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= dec_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_i.valid) begin
      res_q <= res_d;
    end
  end

  always_comb begin
    res_o       = res_q;
    res_o.valid = res_valid_q;
  end

  // blocking fetch keeps decode and execute from holding work together
  a_single_flight: assert property (@(posedge clk_i) disable iff (!reset_l)
    dec_i.valid |-> !res_o.valid);

endmodule

//--- hdl/core_decode.sv
// decode stage, registers each fetch response as a decoded instruction
// output is valid for one cycle, one cycle after the response
`timescale 1ns/1ps
`include "core_defs.svh"

module core_decode
  import core_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_l,
  input  mem_resp_t  mem_resp_i,
  output dec_instr_t dec_o
);

  logic [`CORE_XLEN-1:0] instr;
  dec_instr_t            dec_d;
  dec_instr_t            dec_q;
  logic                  dec_valid_q;

  assign instr = mem_resp_i.rdata;

  ////////////////////////////////////////////////////////////
  // field split
  ////////////////////////////////////////////////////////////

  always_comb begin
    dec_d       = '0;
    dec_d.valid = 1'b1;
    dec_d.op    = instr[31:28];
    dec_d.rd    = instr[26:24];
    dec_d.rs1   = instr[22:20];
    dec_d.rs2   = instr[18:16];
    // sign extend the 16-bit immediate
    dec_d.imm   = {{(`CORE_XLEN-16){instr[15]}}, instr[15:0]};
    // stores and unknown opcodes leave the register file alone
    case (dec_d.op)
      `CORE_OP_ADDI, `CORE_OP_ADD, `CORE_OP_XOR,
      `CORE_OP_HART, `CORE_OP_IRQ: dec_d.wb = 1'b1;
      default: dec_d.wb = 1'b0;
    endcase
  end

  // valid bit
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      dec_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= mem_resp_i.valid;
    end
  end

  // payload only loads on a response
  always_ff @(posedge clk_i) begin
    if (mem_resp_i.valid) begin
      dec_q <= dec_d;
    end
  end

  always_comb begin
    dec_o       = dec_q;
    dec_o.valid = dec_valid_q;
  end

  // one instruction in flight, so responses are never back to back
  a_resp_gap: assert property (@(posedge clk_i) disable iff (!reset_l)
    mem_resp_i.valid |=> !mem_resp_i.valid);

endmodule

//--- hdl/cdc_sync.sv
// two-flop synchronizer for asynchronous levels entering the clk_i domain
// payload type is a parameter, so one module covers single bits and small vectors
`timescale 1ns/1ps

module cdc_sync #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic reset_l,
  input  T     data_i,
  output T     data_o
);

  // first stage may go metastable, second stage is the clean copy
  T meta_q;
  T sync_q;

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= data_i;
      sync_q <= meta_q;
    end
  end

  assign data_o = sync_q;

endmodule

//--- hdl/core_pkg.sv
// types shared by the hart stages and the wrapper
// memory port structs plus the decode and execute stage payloads
`include "core_defs.svh"

package core_pkg;

  // register index, 3 bits for eight registers
  typedef logic [$clog2(`CORE_NREG)-1:0] reg_addr_t;
  typedef logic [3:0] opcode_t;

  // one-cycle request pulse, we high for a store
  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [`CORE_ALEN-1:0] addr;
    logic [`CORE_XLEN-1:0] wdata;
  } mem_req_t;

  // one pulse per read
  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] rdata;
  } mem_resp_t;

  // decode stage output
  typedef struct packed {
    logic                  valid;
    opcode_t               op;
    reg_addr_t             rd;
    reg_addr_t             rs1;
    reg_addr_t             rs2;
    logic [`CORE_XLEN-1:0] imm;
    logic                  wb;
  } dec_instr_t;

  // execute stage output, addr only meaningful for a store
  typedef struct packed {
    logic                  valid;
    reg_addr_t             rd;
    logic                  wb;
    logic                  store;
    logic [`CORE_XLEN-1:0] value;
    logic [`CORE_ALEN-1:0] addr;
  } exe_result_t;

endpackage

//--- hdl/core_defs.svh
// shared widths, register count and opcode encodings for the hart and its wrapper
// include wherever a width or an opcode value is needed
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and byte address widths
`define CORE_XLEN 32
`define CORE_ALEN 16
// architectural register count
`define CORE_NREG 8
// wake-up delay is 2**(bits-1) cycles, 16 bits in silicon
`define CORE_WAKE_BITS 6

// opcode field, instruction bits 31..28
`define CORE_OP_ADDI 4'd0
`define CORE_OP_ADD 4'd1
`define CORE_OP_XOR 4'd2
`define CORE_OP_STORE 4'd3
`define CORE_OP_HART 4'd4
`define CORE_OP_IRQ 4'd5
`endif
